//--- common/synth_consts.svh
`ifndef SYNTH_CONSTS_SVH
`define SYNTH_CONSTS_SVH

// voice engine geometry
`define VOICES      8
`define V_OSC       4
`define OSC_W       2   // log2 of V_OSC
`define VOICE_W     3   // log2 of VOICES

// datapath widths
`define SAMPLE_W    17
`define COEF_W      8
`define ACC_W       48
`define MOD_W       11
`define CFG_W       32

// scaling
`define LEVEL_SHIFT 7   // level_mul product back to sample range
`define MOD_SHIFT   26  // weighted sum down to modulation range

`endif

//--- common/synth_types_pkg.sv
`include "synth_consts.svh"

package synth_types_pkg;

    // operator output sample
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // matrix cell, level or depth
    typedef logic signed [`COEF_W-1:0] coef_t;

    // per-destination running sum
    typedef logic signed [`ACC_W-1:0] acc_t;

    // slot indices
    typedef logic [`OSC_W-1:0] osc_idx_t;
    typedef logic [`VOICE_W-1:0] voice_idx_t;

    // saturated modulation word
    typedef logic signed [`MOD_W-1:0] mod_out_t;

endpackage

//--- common/synth_cfg_pkg.sv
`include "synth_consts.svh"

package synth_cfg_pkg;

    // which per-oscillator depth a level word writes
    typedef enum logic [2:0] {
        LF_LEVEL_MUL    = 3'd0,
        LF_OSC_MOD      = 3'd1,
        LF_OSC_FEEDB    = 3'd2,
        LF_OSC_MOD_IN   = 3'd3,
        LF_OSC_FEEDB_IN = 3'd4
    } level_field_e;

    // kind 0, one matrix cell
    typedef struct packed {
        logic                      kind;
        logic                      is_fb;     // feedback matrix when set
        synth_types_pkg::osc_idx_t dest;
        synth_types_pkg::osc_idx_t src;
        logic [`CFG_W-2-2*`OSC_W-`COEF_W-1:0] rsvd;
        synth_types_pkg::coef_t    value;
    } cfg_coef_t;

    // kind 1, one per-oscillator depth
    typedef struct packed {
        logic                      kind;
        synth_types_pkg::osc_idx_t osc;
        level_field_e              field;
        logic [`CFG_W-4-`OSC_W-`COEF_W-1:0] rsvd;
        synth_types_pkg::coef_t    value;
    } cfg_level_t;

    // both views share bit 31 as the kind bit
    typedef union packed {
        cfg_coef_t  coef;
        cfg_level_t level;
    } cfg_word_u;

endpackage

//--- logic/slot_sequencer.sv
`timescale 1ns/10ps
`include "synth_consts.svh"

module slot_sequencer (
    input  logic                        sCLK_XVXENVS,
    input  logic                        reset,
    input  logic                        accept,
    output synth_types_pkg::osc_idx_t   osc_idx,
    output synth_types_pkg::voice_idx_t voice_idx,
    output logic                        voice_last
);
    import synth_types_pkg::*;

    localparam osc_idx_t   OSC_LAST   = osc_idx_t'(`V_OSC - 1);
    localparam voice_idx_t VOICE_LAST = voice_idx_t'(`VOICES - 1);

    assign voice_last = (osc_idx == OSC_LAST);

    // osc minor, voice major
    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            osc_idx   <= '0;
            voice_idx <= '0;
        end else if (accept) begin
            if (voice_last) begin
                osc_idx <= '0;
                if (voice_idx == VOICE_LAST) begin
                    voice_idx <= '0;        // frame wrap
                end else begin
                    voice_idx <= voice_idx + 1'b1;
                end
            end else begin
                osc_idx <= osc_idx + 1'b1;
            end
        end
    end

    a_voice_step: assert property (@(posedge sCLK_XVXENVS) disable iff (reset)
        (voice_idx != $past(voice_idx)) |-> $past(accept && voice_last))
        else $error("voice index moved without a voice-end acceptance");

endmodule

//--- mod_matrix/matrix_coef_store.sv
`timescale 1ns/10ps
`include "synth_consts.svh"

module matrix_coef_store (
    input  logic                       sCLK_XVXENVS,
    input  logic                       reset,
    input  logic                       cfg_valid,
    output logic                       cfg_ready,
    input  synth_cfg_pkg::cfg_word_u   cfg_word,
    input  logic                       busy,
    output synth_types_pkg::coef_t     mat_mod [`V_OSC][`V_OSC],
    output synth_types_pkg::coef_t     mat_fb [`V_OSC][`V_OSC],
    output synth_types_pkg::coef_t     level_mul [`V_OSC],
    output synth_types_pkg::coef_t     osc_mod [`V_OSC],
    output synth_types_pkg::coef_t     osc_feedb [`V_OSC],
    output synth_types_pkg::coef_t     osc_mod_in [`V_OSC],
    output synth_types_pkg::coef_t     osc_feedb_in [`V_OSC]
);
    import synth_cfg_pkg::*;

    logic cfg_take;

    assign cfg_ready = !busy;   // only between voices
    assign cfg_take  = cfg_valid && cfg_ready;

    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            for (int i = 0; i < `V_OSC; i++) begin
                level_mul[i]    <= '0;
                osc_mod[i]      <= '0;
                osc_feedb[i]    <= '0;
                osc_mod_in[i]   <= '0;
                osc_feedb_in[i] <= '0;
                for (int j = 0; j < `V_OSC; j++) begin
                    mat_mod[i][j] <= '0;
                    mat_fb[i][j]  <= '0;
                end
            end
        end else if (cfg_take) begin
            if (!cfg_word.coef.kind) begin
                if (cfg_word.coef.is_fb) begin
                    mat_fb[cfg_word.coef.dest][cfg_word.coef.src] <= cfg_word.coef.value;
                end else begin
                    mat_mod[cfg_word.coef.dest][cfg_word.coef.src] <= cfg_word.coef.value;
                end
            end else begin
                case (cfg_word.level.field)
                    LF_LEVEL_MUL:    level_mul[cfg_word.level.osc]    <= cfg_word.level.value;
                    LF_OSC_MOD:      osc_mod[cfg_word.level.osc]      <= cfg_word.level.value;
                    LF_OSC_FEEDB:    osc_feedb[cfg_word.level.osc]    <= cfg_word.level.value;
                    LF_OSC_MOD_IN:   osc_mod_in[cfg_word.level.osc]   <= cfg_word.level.value;
                    LF_OSC_FEEDB_IN: osc_feedb_in[cfg_word.level.osc] <= cfg_word.level.value;
                    default: ;      // unknown field, word dropped
                endcase
            end
        end
    end

    a_field_range: assert property (@(posedge sCLK_XVXENVS) disable iff (reset)
        (cfg_take && cfg_word.level.kind) |-> (cfg_word.level.field <= LF_OSC_FEEDB_IN))
        else $error("level word with out-of-range field select");

endmodule

//--- mod_matrix/mod_matrix.sv
`timescale 1ns/10ps
`include "synth_consts.svh"

module mod_matrix (
    input  logic                        sCLK_XVXENVS,
    input  logic                        reset,
    input  logic                        sample_valid,
    output logic                        sample_ready,
    input  synth_types_pkg::sample_t    sample,
    input  synth_types_pkg::osc_idx_t   osc_idx,
    input  synth_types_pkg::voice_idx_t voice_idx,
    input  logic                        voice_last,
    input  synth_types_pkg::coef_t      mat_mod [`V_OSC][`V_OSC],
    input  synth_types_pkg::coef_t      mat_fb [`V_OSC][`V_OSC],
    input  synth_types_pkg::coef_t      level_mul [`V_OSC],
    input  synth_types_pkg::coef_t      osc_mod [`V_OSC],
    input  synth_types_pkg::coef_t      osc_feedb [`V_OSC],
    output logic                        busy,
    output logic                        load_valid,
    input  logic                        load_ready,
    output synth_types_pkg::acc_t       mod_sums [`V_OSC],
    output synth_types_pkg::acc_t       fb_sums [`V_OSC],
    output synth_types_pkg::voice_idx_t load_voice
);
    import synth_types_pkg::*;

    logic       accept;
    logic       stall;
    logic       acc_nonzero;
    acc_t       m_next, f_next;
    logic       p_valid;            // product stage occupied
    acc_t       p_m, p_f;
    osc_idx_t   p_osc;
    voice_idx_t p_voice;
    logic       p_last;
    acc_t       mod_acc [`V_OSC];
    acc_t       fb_acc [`V_OSC];
    acc_t       mod_contrib [`V_OSC];
    acc_t       fb_contrib [`V_OSC];

    // voice end cannot hand off while the output stage still holds the last one
    assign stall        = p_valid && p_last && (load_valid || !load_ready);
    assign sample_ready = !stall;
    assign accept       = sample_valid && sample_ready;

    assign m_next = (acc_t'(level_mul[osc_idx]) * acc_t'(sample) * acc_t'(osc_mod[osc_idx]))
                    >>> `LEVEL_SHIFT;
    assign f_next = acc_t'(sample) * acc_t'(osc_feedb[osc_idx]);

    always_comb begin
        for (int d = 0; d < `V_OSC; d++) begin
            mod_contrib[d] = p_m * acc_t'(mat_mod[d][p_osc]);   // fan-out to each dest
            fb_contrib[d]  = p_f * acc_t'(mat_fb[d][p_osc]);
        end
    end

    always_comb begin
        acc_nonzero = 1'b0;
        for (int d = 0; d < `V_OSC; d++) begin
            if (mod_acc[d] != '0 || fb_acc[d] != '0) begin
                acc_nonzero = 1'b1;
            end
        end
    end

    assign busy = p_valid || acc_nonzero;

    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            p_valid    <= 1'b0;
            load_valid <= 1'b0;
            for (int d = 0; d < `V_OSC; d++) begin
                mod_acc[d] <= '0;
                fb_acc[d]  <= '0;
            end
        end else begin
            if (load_valid && load_ready) begin
                load_valid <= 1'b0;
            end
            if (!stall) begin
                p_valid <= accept;
                if (p_valid && p_last) begin
                    load_valid <= 1'b1;             // sums latched below
                    for (int d = 0; d < `V_OSC; d++) begin
                        mod_acc[d] <= '0;
                        fb_acc[d]  <= '0;
                    end
                end else if (p_valid) begin
                    for (int d = 0; d < `V_OSC; d++) begin
                        mod_acc[d] <= mod_acc[d] + mod_contrib[d];
                        fb_acc[d]  <= fb_acc[d] + fb_contrib[d];
                    end
                end
            end
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (accept) begin
            p_m     <= m_next;
            p_f     <= f_next;
            p_osc   <= osc_idx;
            p_voice <= voice_idx;
            p_last  <= voice_last;
        end
        if (!stall && p_valid && p_last) begin
            for (int d = 0; d < `V_OSC; d++) begin
                mod_sums[d] <= mod_acc[d] + mod_contrib[d];   // include the last slot
                fb_sums[d]  <= fb_acc[d] + fb_contrib[d];
            end
            load_voice <= p_voice;
        end
    end

    // a new voice is handed over only when the output stage is free
    a_load_free: assert property (@(posedge sCLK_XVXENVS) disable iff (reset)
        $rose(load_valid) |-> load_ready)
        else $error("load_valid rose while output stage busy");

endmodule

//--- logic/mod_output_stage.sv
`timescale 1ns/10ps
`include "synth_consts.svh"

module mod_output_stage (
    input  logic                        sCLK_XVXENVS,
    input  logic                        reset,
    input  logic                        load_valid,
    output logic                        load_ready,
    input  synth_types_pkg::acc_t       mod_sums [`V_OSC],
    input  synth_types_pkg::acc_t       fb_sums [`V_OSC],
    input  synth_types_pkg::voice_idx_t load_voice,
    input  synth_types_pkg::coef_t      osc_mod_in [`V_OSC],
    input  synth_types_pkg::coef_t      osc_feedb_in [`V_OSC],
    output logic                        mod_valid,
    input  logic                        mod_ready,
    output synth_types_pkg::mod_out_t   mod_word,
    output synth_types_pkg::voice_idx_t mod_voice,
    output synth_types_pkg::osc_idx_t   mod_dest
);
    import synth_types_pkg::*;

    localparam osc_idx_t DST_LAST = osc_idx_t'(`V_OSC - 1);
    localparam acc_t     SAT_MAX  = acc_t'(2 ** (`MOD_W - 1) - 1);
    localparam acc_t     SAT_MIN  = -SAT_MAX - 1;

    logic     load_take, out_take;
    osc_idx_t dst;
    osc_idx_t sel;          // destination the next word is built from
    acc_t     weighted, shifted;
    mod_out_t sat_word;

    assign load_take = load_valid && load_ready;
    assign out_take  = mod_valid && mod_ready;
    assign sel       = load_take ? '0 : osc_idx_t'(dst + 1'b1);

    assign weighted = mod_sums[sel] * acc_t'(osc_mod_in[sel])
                    + fb_sums[sel] * acc_t'(osc_feedb_in[sel]);
    assign shifted  = weighted >>> `MOD_SHIFT;

    always_comb begin
        if (shifted > SAT_MAX) begin
            sat_word = mod_out_t'(SAT_MAX);
        end else if (shifted < SAT_MIN) begin
            sat_word = mod_out_t'(SAT_MIN);
        end else begin
            sat_word = mod_out_t'(shifted);
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            load_ready <= 1'b1;
            mod_valid  <= 1'b0;
            dst        <= '0;
        end else if (load_take) begin
            load_ready <= 1'b0;
            mod_valid  <= 1'b1;     // dest 0 ready next cycle
            dst        <= '0;
        end else if (out_take) begin
            if (dst == DST_LAST) begin
                mod_valid  <= 1'b0;
                load_ready <= 1'b1;
            end else begin
                dst <= dst + 1'b1;
            end
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (load_take || (out_take && dst != DST_LAST)) begin
            mod_word <= sat_word;
        end
        if (load_take) begin
            mod_voice <= load_voice;
        end
    end

    assign mod_dest = dst;

    a_word_hold: assert property (@(posedge sCLK_XVXENVS) disable iff (reset)
        (mod_valid && !mod_ready) |=> (mod_valid && $stable(mod_word)))
        else $error("mod_word changed while stalled");

endmodule

//--- logic/fm_mod_top.sv
`timescale 1ns/10ps
`include "synth_consts.svh"

module fm_mod_top (
    input  logic                        sCLK_XVXENVS,
    input  logic                        reset,
    input  logic                        sample_valid,
    output logic                        sample_ready,
    input  synth_types_pkg::sample_t    sample,
    output logic                        mod_valid,
    input  logic                        mod_ready,
    output synth_types_pkg::mod_out_t   mod_word,
    output synth_types_pkg::voice_idx_t mod_voice,
    output synth_types_pkg::osc_idx_t   mod_dest,
    input  logic                        cfg_valid,
    output logic                        cfg_ready,
    input  synth_cfg_pkg::cfg_word_u    cfg_word
);
    import synth_types_pkg::*;

    logic       accept;
    osc_idx_t   osc_idx;
    voice_idx_t voice_idx;
    logic       voice_last;
    logic       busy;
    logic       load_valid, load_ready;
    voice_idx_t load_voice;
    acc_t       mod_sums [`V_OSC];
    acc_t       fb_sums [`V_OSC];
    coef_t      mat_mod [`V_OSC][`V_OSC];
    coef_t      mat_fb [`V_OSC][`V_OSC];
    coef_t      level_mul [`V_OSC];
    coef_t      osc_mod [`V_OSC];
    coef_t      osc_feedb [`V_OSC];
    coef_t      osc_mod_in [`V_OSC];
    coef_t      osc_feedb_in [`V_OSC];

    assign accept = sample_valid && sample_ready;

    slot_sequencer u_seq (
        .sCLK_XVXENVS(sCLK_XVXENVS), .reset(reset), .accept(accept),
        .osc_idx(osc_idx), .voice_idx(voice_idx), .voice_last(voice_last)
    );

    matrix_coef_store u_coef (
        .sCLK_XVXENVS(sCLK_XVXENVS), .reset(reset),
        .cfg_valid(cfg_valid), .cfg_ready(cfg_ready), .cfg_word(cfg_word), .busy(busy),
        .mat_mod(mat_mod), .mat_fb(mat_fb), .level_mul(level_mul),
        .osc_mod(osc_mod), .osc_feedb(osc_feedb),
        .osc_mod_in(osc_mod_in), .osc_feedb_in(osc_feedb_in)
    );

    mod_matrix u_matrix (
        .sCLK_XVXENVS(sCLK_XVXENVS), .reset(reset),
        .sample_valid(sample_valid), .sample_ready(sample_ready), .sample(sample),
        .osc_idx(osc_idx), .voice_idx(voice_idx), .voice_last(voice_last),
        .mat_mod(mat_mod), .mat_fb(mat_fb), .level_mul(level_mul),
        .osc_mod(osc_mod), .osc_feedb(osc_feedb), .busy(busy),
        .load_valid(load_valid), .load_ready(load_ready),
        .mod_sums(mod_sums), .fb_sums(fb_sums), .load_voice(load_voice)
    );

    mod_output_stage u_out (
        .sCLK_XVXENVS(sCLK_XVXENVS), .reset(reset),
        .load_valid(load_valid), .load_ready(load_ready),
        .mod_sums(mod_sums), .fb_sums(fb_sums), .load_voice(load_voice),
        .osc_mod_in(osc_mod_in), .osc_feedb_in(osc_feedb_in),
        .mod_valid(mod_valid), .mod_ready(mod_ready), .mod_word(mod_word),
        .mod_voice(mod_voice), .mod_dest(mod_dest)
    );

endmodule

//--- sim/tb_fm_mod.sv
`timescale 1ns/10ps
`include "synth_consts.svh"

module tb_fm_mod;
    import synth_types_pkg::*;

    logic                      sCLK_XVXENVS;
    logic                      reset;
    logic                      sample_valid;
    logic                      sample_ready;
    sample_t                   sample;
    logic                      mod_valid;
    logic                      mod_ready;
    mod_out_t                  mod_word;
    voice_idx_t                mod_voice;
    osc_idx_t                  mod_dest;
    logic                      cfg_valid;
    logic                      cfg_ready;
    synth_cfg_pkg::cfg_word_u  cfg_word;

    logic [35:0] pat [0:127];       // tag nibble plus 32-bit data
    logic [31:0] exp_q [$];         // voice, dest, word
    logic [31:0] drive_state;
    logic [31:0] ready_state;
    logic        hold_ready;
    int          errors;
    int          test_errors;
    int          test_num;
    int          tests_done;
    int          cycles;
    int          limit;

    fm_mod_top dut (
        .sCLK_XVXENVS(sCLK_XVXENVS), .reset(reset),
        .sample_valid(sample_valid), .sample_ready(sample_ready), .sample(sample),
        .mod_valid(mod_valid), .mod_ready(mod_ready), .mod_word(mod_word),
        .mod_voice(mod_voice), .mod_dest(mod_dest),
        .cfg_valid(cfg_valid), .cfg_ready(cfg_ready), .cfg_word(cfg_word)
    );

    initial begin
        sCLK_XVXENVS = 1'b0;
        forever #20 sCLK_XVXENVS = ~sCLK_XVXENVS;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_error(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        errors++;
        test_errors++;
    endtask

    task automatic check_mod(input mod_out_t got, input mod_out_t want, input string what);
        if (got !== want) begin
            report_error($sformatf("%s word %0d, expected %0d", what, got, want));
        end
    endtask

    task automatic check_voice(input voice_idx_t got, input voice_idx_t want);
        if (got !== want) begin
            report_error($sformatf("mod_voice %0d, expected %0d", got, want));
        end
    endtask

    task automatic check_dest(input osc_idx_t got, input osc_idx_t want);
        if (got !== want) begin
            report_error($sformatf("mod_dest %0d, expected %0d", got, want));
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want) begin
            report_error($sformatf("%s is %b, expected %b", what, got, want));
        end
    endtask

    // wait until every expected word is out
    task automatic wait_idle();
        while (exp_q.size() != 0 || mod_valid) begin
            @(negedge sCLK_XVXENVS);
        end
    endtask

    task automatic write_cfg(input logic [31:0] w);
        wait_idle();
        cfg_valid = 1'b1;
        cfg_word  = w;
        while (!cfg_ready) begin
            @(negedge sCLK_XVXENVS);
        end
        @(negedge sCLK_XVXENVS);
        cfg_valid = 1'b0;
    endtask

    task automatic send_sample(input logic [31:0] d);
        drive_state = lcg_step(drive_state);
        repeat (drive_state[25:24] % 3) @(negedge sCLK_XVXENVS);   // random gap
        sample_valid = 1'b1;
        sample       = sample_t'(d[`SAMPLE_W-1:0]);
        while (!sample_ready) begin
            @(negedge sCLK_XVXENVS);
        end
        @(negedge sCLK_XVXENVS);
        sample_valid = 1'b0;
        check_flag(cfg_ready, 1'b0, "cfg_ready with a sample in flight");
    endtask

    task automatic finish_test();
        if (test_num > 0) begin
            wait_idle();
            $display("test %0d done, %0d errors", test_num, test_errors);
            tests_done++;
        end
        test_errors = 0;
    endtask

    // output side, decides mod_ready and checks each transfer before it happens
    always @(negedge sCLK_XVXENVS) begin
        logic       rdy;
        logic [31:0] e;
        ready_state = lcg_step(ready_state);
        rdy         = !hold_ready && ready_state[20];
        mod_ready   = rdy;
        if (mod_valid && rdy) begin
            if (exp_q.size() == 0) begin
                $display("extra modulation word %0d with no expected value at %0t ns",
                         mod_word, $time);
                errors++;
                test_errors++;
            end else begin
                e = exp_q.pop_front();
                check_voice(mod_voice, voice_idx_t'(e[22:20]));
                check_dest(mod_dest, osc_idx_t'(e[17:16]));
                check_mod(mod_word, mod_out_t'(e[10:0]), "modulation");
            end
        end
    end

    // watchdog
    initial begin
        cycles = 0;
        wait (limit > 0);
        forever begin
            @(posedge sCLK_XVXENVS);
            cycles++;
            if (cycles > limit) begin
                $display("timeout: run did not finish within %0d cycles", limit);
                $display("Test FAILED");
                $finish;
            end
        end
    end

    initial begin
        int          idx;
        logic [3:0]  tag;
        logic [31:0] data;
        reset        = 1'b1;
        sample_valid = 1'b0;
        sample       = '0;
        mod_ready    = 1'b0;
        cfg_valid    = 1'b0;
        cfg_word     = '0;
        hold_ready   = 1'b0;
        drive_state  = 32'h6bd9e64f;
        ready_state  = lcg_step(32'h6bd9e64f);
        errors       = 0;
        test_errors  = 0;
        test_num     = 0;
        tests_done   = 0;
        limit        = 0;
        $readmemh("sim/mod_patterns.txt", pat);
        idx = 0;
        while (idx < 127 && pat[idx][35:32] !== 4'hF) begin
            idx++;
        end
        limit = (idx + 1) * `V_OSC * 20;
        repeat (8) @(posedge sCLK_XVXENVS);
        @(negedge sCLK_XVXENVS);
        reset = 1'b0;
        @(negedge sCLK_XVXENVS);
        idx = 0;
        while (pat[idx][35:32] !== 4'hF) begin
            tag  = pat[idx][35:32];
            data = pat[idx][31:0];
            case (tag)
                4'h1: write_cfg(data);
                4'h2: send_sample(data);
                4'h3: exp_q.push_back(data);
                4'h4: hold_ready = data[0];
                4'h5: begin
                    repeat (4) @(negedge sCLK_XVXENVS);  // let the pipeline settle
                    check_flag(sample_ready, data[0], "sample_ready");
                    check_flag(cfg_ready, data[1], "cfg_ready");
                    check_flag(mod_valid, data[2], "mod_valid");
                end
                4'h6: wait_idle();
                4'h7: begin
                    finish_test();
                    test_num = data;
                end
                default: begin
                    $display("pattern record %0d has unknown tag %h", idx, tag);
                    errors++;
                end
            endcase
            idx++;
        end
        finish_test();
        $display("%0d tests, %0d errors", tests_done, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- sim/mod_patterns.txt
// tag then data: 1 cfg word, 2 sample, 3 expect (voice [22:20], dest [17:16], word [10:0])
// 4 hold mod_ready low, 5 status (ready, cfg_ready, mod_valid), 6 wait idle, 7 test start, F end
700000001
500000003
200001000
200001000
200001000
200001000
300000000
300010000
300020000
300030000
700000002
180000040
184000040
110000040
1AC000040
200004000
200001000
200001000
200001000
300100000
300110020
300120000
300130000
700000003
1C8000040
178000020
1F0000040
200008000
200000000
20000A000
200000000
300200000
300210040
300220000
300230050
1E800007F
14C00007F
16C000080
19000007F
1D000007F
200000000
200000000
200000000
20000FFFF
3003003FF
300310000
300320400
300330000
700000004
400000001
200008000
200000000
20000A000
200000000
300400000
300410040
300420000
300430050
200018000
200000000
200000000
200000000
300500000
3005107C0
300520000
300530000
500000004
400000000
700000005
200008000
200000000
20000A000
200000000
300600000
300610040
300620000
300630050
200000000
200000000
200000000
20000FFFF
3007003FF
300710000
300720400
300730000
700000006
600000000
500000003
F00000000

//--- src.f
+incdir+common
common/synth_types_pkg.sv
common/synth_cfg_pkg.sv
logic/slot_sequencer.sv
mod_matrix/matrix_coef_store.sv
mod_matrix/mod_matrix.sv
logic/mod_output_stage.sv
logic/fm_mod_top.sv
sim/tb_fm_mod.sv

//--- run_sim.sh
#!/bin/bash
# build and run the modulation matrix testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f src.f --top-module tb_fm_mod -o tb_fm_mod
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_fm_mod > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0
